// File: include/mcpu_cfg.svh
`ifndef MCPU_CFG_SVH
`define MCPU_CFG_SVH

// Data and address width
`define MCPU_XLEN 32

// Architectural register count
`define MCPU_NREGS 32

// First fetch address after reset
`define MCPU_RESET_PC 32'h0000_0000

// Word address bits decoded by the memory behind the APB port
`define MCPU_MEM_AW 10

`endif

// File: src/isaPkg.sv
`default_nettype none

`include "mcpu_cfg.svh"

package isaPkg;

    typedef logic [`MCPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`MCPU_NREGS)-1:0] regIdx_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OpR      = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111,
        OpSystem = 7'b1110011
    } opcode_t;

    // funct3 of the kept ALU operations; beq, lw, sw and jalr use 000 or 010
    typedef enum logic [2:0] {
        F3AddSub = 3'b000,
        F3Slt    = 3'b010,
        F3Or     = 3'b110,
        F3And    = 3'b111
    } funct3_t;

    typedef enum logic [2:0] {
        ImmI,
        ImmS,
        ImmB,
        ImmU,
        ImmJ
    } immKind_t;

endpackage

`default_nettype wire

// File: src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [4:0] {
        Fetch, FetchWait, Decode, ExecR, ExecI, MemAddr,
        LoadReq, LoadWait, StoreReq, StoreWait, LoadWb, AluWb,
        Branch, Jal, Jalr, Lui, Halt, Fault
    } cpuState_t;

    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluSlt
    } aluOp_t;

    typedef enum logic [1:0] {SrcAPc, SrcARs1, SrcAZero} srcA_t;
    typedef enum logic [1:0] {SrcBRs2, SrcBFour, SrcBImm} srcB_t;
    typedef enum logic [1:0] {SelAdd, SelCompare, SelFunct} aluOpSel_t;

    // Live ALU result, ALU-out register, or live result with bit 0 cleared
    typedef enum logic [1:0] {PcAlu, PcAluOut, PcJalr} pcSrc_t;

    typedef struct packed {
        logic      pcWrite;
        logic      pcWriteCond;
        logic      iOrD;
        logic      irWrite;
        logic      memToReg;
        pcSrc_t    pcSource;
        srcA_t     aluSrcA;
        srcB_t     aluSrcB;
        aluOpSel_t aluOpSel;
        logic      regWrite;
        logic      apbSel;
        logic      apbEnable;
        logic      apbWrite;
    } ctrl_t;

    typedef struct packed {
        logic          psel;
        logic          penable;
        logic          pwrite;
        isaPkg::word_t paddr;
        isaPkg::word_t pwdata;
    } apbReq_t;

    typedef struct packed {
        isaPkg::word_t prdata;
        logic          pready;
        logic          pslverr;
    } apbRsp_t;

endpackage

`default_nettype wire

// File: src/controlFsm.sv
`default_nettype none

module controlFsm (
    input  wire                clk,
    input  wire                rstN,
    input  isaPkg::opcode_t    opcode,
    input  isaPkg::funct3_t    funct3,
    input  wire                funct7b5,
    input  wire                zero,
    input  ctrlPkg::apbRsp_t   apbRsp,
    output ctrlPkg::cpuState_t state,
    output ctrlPkg::aluOp_t    aluOp,
    output logic               halted,
    output logic               fault
);
    import isaPkg::*;
    import ctrlPkg::*;

    cpuState_t nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Fetch:    nextState = FetchWait;
            FetchWait, LoadWait, StoreWait: begin
                // Hold until the completer ends the transfer
                if (apbRsp.pready) begin
                    if (apbRsp.pslverr) begin
                        nextState = Fault;
                    end else if (state == FetchWait) begin
                        nextState = Decode;
                    end else if (state == LoadWait) begin
                        nextState = LoadWb;
                    end else begin
                        nextState = Fetch;
                    end
                end
            end
            Decode: begin
                case (opcode)
                    OpR:      nextState = ExecR;
                    OpImm:    nextState = (funct3 == F3AddSub) ? ExecI : Fault;
                    OpLoad,
                    OpStore:  nextState = MemAddr;
                    OpBranch: nextState = (funct3 == F3AddSub) ? Branch : Fault;
                    OpJal:    nextState = Jal;
                    OpJalr:   nextState = Jalr;
                    OpLui:    nextState = Lui;
                    OpSystem: nextState = Halt;
                    default:  nextState = Fault;
                endcase
            end
            MemAddr:  nextState = (opcode == OpLoad) ? LoadReq : StoreReq;
            LoadReq:  nextState = LoadWait;
            StoreReq: nextState = StoreWait;
            ExecR:    nextState = AluWb;
            ExecI:    nextState = AluWb;
            AluWb, LoadWb, Branch, Jal, Jalr, Lui: nextState = Fetch;
            Halt:     nextState = Halt;
            default:  nextState = Fault;
        endcase
    end

    // Only R-type looks at funct; addi always adds
    always_comb begin
        aluOp = AluAdd;
        if (state == ExecR) begin
            case (funct3)
                F3AddSub: aluOp = funct7b5 ? AluSub : AluAdd;
                F3Slt:    aluOp = AluSlt;
                F3Or:     aluOp = AluOr;
                F3And:    aluOp = AluAnd;
                default:  aluOp = AluAdd;
            endcase
        end
    end

    assign halted = (state == Halt);
    assign fault  = (state == Fault);

    // Terminal states are left only through reset
    aHaltSticky: assert property (@(posedge clk) disable iff (!rstN)
        (state == Halt) |=> (state == Halt));
    aFaultSticky: assert property (@(posedge clk) disable iff (!rstN)
        (state == Fault) |=> (state == Fault));

    // The compare result from the datapath must be resolved when beq commits
    aZeroKnown: assert property (@(posedge clk) disable iff (!rstN)
        (state == Branch) |-> !$isunknown(zero));

endmodule

`default_nettype wire

// File: src/controlDecode.sv
`default_nettype none

module controlDecode (
    input  ctrlPkg::cpuState_t state,
    output ctrlPkg::ctrl_t     ctrl
);
    import ctrlPkg::*;

    always_comb begin
        ctrl          = '0;
        ctrl.aluSrcA  = SrcAPc;
        ctrl.aluSrcB  = SrcBRs2;
        ctrl.aluOpSel = SelAdd;
        ctrl.pcSource = PcAlu;
        case (state)
            Fetch: ctrl.apbSel = 1'b1;
            FetchWait: begin
                // Instruction lands in IR while PC moves to PC + 4
                ctrl.apbSel    = 1'b1;
                ctrl.apbEnable = 1'b1;
                ctrl.irWrite   = 1'b1;
                ctrl.pcWrite   = 1'b1;
                ctrl.aluSrcB   = SrcBFour;
            end
            Decode: begin
                // Branch and jal target ahead of time
                ctrl.aluSrcB = SrcBImm;
            end
            ExecR: begin
                ctrl.aluSrcA  = SrcARs1;
                ctrl.aluOpSel = SelFunct;
            end
            ExecI: begin
                ctrl.aluSrcA  = SrcARs1;
                ctrl.aluSrcB  = SrcBImm;
                ctrl.aluOpSel = SelFunct;
            end
            MemAddr: begin
                ctrl.aluSrcA = SrcARs1;
                ctrl.aluSrcB = SrcBImm;
            end
            LoadReq: begin
                ctrl.apbSel = 1'b1;
                ctrl.iOrD   = 1'b1;
            end
            LoadWait: begin
                ctrl.apbSel    = 1'b1;
                ctrl.apbEnable = 1'b1;
                ctrl.iOrD      = 1'b1;
            end
            StoreReq: begin
                ctrl.apbSel   = 1'b1;
                ctrl.apbWrite = 1'b1;
                ctrl.iOrD     = 1'b1;
            end
            StoreWait: begin
                ctrl.apbSel    = 1'b1;
                ctrl.apbEnable = 1'b1;
                ctrl.apbWrite  = 1'b1;
                ctrl.iOrD      = 1'b1;
            end
            LoadWb: begin
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            AluWb: ctrl.regWrite = 1'b1;
            Branch: begin
                ctrl.aluSrcA     = SrcARs1;
                ctrl.aluOpSel    = SelCompare;
                ctrl.pcWriteCond = 1'b1;
                ctrl.pcSource    = PcAluOut;
            end
            Jal: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PcAluOut;
                ctrl.regWrite = 1'b1;
            end
            Jalr: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PcJalr;
                ctrl.aluSrcA  = SrcARs1;
                ctrl.aluSrcB  = SrcBImm;
                ctrl.regWrite = 1'b1;
            end
            Lui: begin
                ctrl.aluSrcA  = SrcAZero;
                ctrl.aluSrcB  = SrcBImm;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    aEnableNeedsSel: assert final (!ctrl.apbEnable || ctrl.apbSel);

endmodule

`default_nettype wire

// File: src/regFile.sv
`default_nettype none

`include "mcpu_cfg.svh"

module regFile (
    input  wire              clk,
    input  wire              we,
    input  isaPkg::regIdx_t  ra1,
    input  isaPkg::regIdx_t  ra2,
    input  isaPkg::regIdx_t  wa,
    input  isaPkg::word_t    wd,
    output isaPkg::word_t    rd1,
    output isaPkg::word_t    rd2
);
    import isaPkg::*;

    word_t regs [`MCPU_NREGS];

    // x0 is never written, so its read mux forces zero
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: src/aluUnit.sv
`default_nettype none

module aluUnit (
    input  isaPkg::word_t    a,
    input  isaPkg::word_t    b,
    input  isaPkg::word_t    instr,
    input  isaPkg::immKind_t immKind,
    input  ctrlPkg::aluOp_t  aluOp,
    output isaPkg::word_t    result,
    output isaPkg::word_t    imm,
    output logic             zero
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        case (aluOp)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluSlt:  result = {31'b0, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

    // Immediates are sign-extended from instr[31]
    always_comb begin
        case (immKind)
            ImmS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            ImmB:    imm = {{19{instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};
            ImmU:    imm = {instr[31:12], 12'b0};
            ImmJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: src/datapath.sv
`default_nettype none

`include "mcpu_cfg.svh"

module datapath (
    input  wire               clk,
    input  wire               rstN,
    input  ctrlPkg::ctrl_t    ctrl,
    input  ctrlPkg::aluOp_t   aluOp,
    input  ctrlPkg::apbRsp_t  apbRsp,
    output ctrlPkg::apbReq_t  apbReq,
    output isaPkg::opcode_t   opcode,
    output isaPkg::funct3_t   funct3,
    output logic              funct7b5,
    output logic              zero,
    output isaPkg::word_t     pc
);
    import isaPkg::*;
    import ctrlPkg::*;

    word_t    pcPrev, ir, mdr, aluOut, regA, regB;
    word_t    rd1, rd2, wd, srcA, srcB, aluResult, imm, pcNext;
    immKind_t immKind;
    aluOp_t   aluOpEff;
    logic     accessDone, pcLoad;

    assign accessDone = ctrl.apbEnable && apbRsp.pready;
    // Writes tied to an access phase wait for pready
    assign pcLoad = (ctrl.pcWrite && (!ctrl.apbEnable || apbRsp.pready))
                  || (ctrl.pcWriteCond && zero);

    always_comb begin
        case (ctrl.pcSource)
            PcAluOut: pcNext = aluOut;
            PcJalr:   pcNext = {aluResult[31:1], 1'b0};
            default:  pcNext = aluResult;
        endcase
    end

    // pcPrev trails pc by one update, so it holds the address of the
    // instruction in IR from Decode on and equals pc during the fetch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= `MCPU_RESET_PC;
            pcPrev <= `MCPU_RESET_PC;
            ir     <= '0;
        end else begin
            if (pcLoad) begin
                pc <= pcNext;
            end else begin
                pcPrev <= pc;
            end
            if (ctrl.irWrite && apbRsp.pready) begin
                ir <= apbRsp.prdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        regA <= rd1;
        regB <= rd2;
        if (accessDone && !ctrl.apbWrite) begin
            mdr <= apbRsp.prdata;
        end
        // Held through memory accesses, where it supplies paddr
        if (!ctrl.apbSel) begin
            aluOut <= aluResult;
        end
    end

    assign opcode   = opcode_t'(ir[6:0]);
    assign funct3   = funct3_t'(ir[14:12]);
    assign funct7b5 = ir[30];

    always_comb begin
        case (opcode)
            OpStore:  immKind = ImmS;
            OpBranch: immKind = ImmB;
            OpJal:    immKind = ImmJ;
            OpLui:    immKind = ImmU;
            default:  immKind = ImmI;
        endcase
    end

    always_comb begin
        case (ctrl.aluSrcA)
            SrcARs1:  srcA = regA;
            SrcAZero: srcA = '0;
            default:  srcA = pcPrev;
        endcase
        case (ctrl.aluSrcB)
            SrcBFour: srcB = 32'd4;
            SrcBImm:  srcB = imm;
            default:  srcB = regB;
        endcase
        case (ctrl.aluOpSel)
            SelCompare: aluOpEff = AluSub;
            SelFunct:   aluOpEff = aluOp;
            default:    aluOpEff = AluAdd;
        endcase
    end

    // Jumps link the incremented PC, lui takes the live sum with zero
    always_comb begin
        if (ctrl.memToReg) begin
            wd = mdr;
        end else if (ctrl.pcWrite) begin
            wd = pc;
        end else if (ctrl.aluSrcA == SrcAZero) begin
            wd = aluResult;
        end else begin
            wd = aluOut;
        end
    end

    regFile uRegFile (
        .clk (clk),
        .we  (ctrl.regWrite),
        .ra1 (regIdx_t'(ir[19:15])),
        .ra2 (regIdx_t'(ir[24:20])),
        .wa  (regIdx_t'(ir[11:7])),
        .wd  (wd),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    aluUnit uAlu (
        .a       (srcA),
        .b       (srcB),
        .instr   (ir),
        .immKind (immKind),
        .aluOp   (aluOpEff),
        .result  (aluResult),
        .imm     (imm),
        .zero    (zero)
    );

    assign apbReq = '{
        psel:    ctrl.apbSel,
        penable: ctrl.apbEnable,
        pwrite:  ctrl.apbWrite,
        paddr:   ctrl.iOrD ? aluOut : pc,
        pwdata:  regB
    };

    // Setup phase is always followed by the access phase
    aApbSetup: assert property (@(posedge clk) disable iff (!rstN)
        (apbReq.psel && !apbReq.penable) |=> (apbReq.psel && apbReq.penable));
    // Access phase holds until pready
    aApbHold: assert property (@(posedge clk) disable iff (!rstN)
        (apbReq.penable && !apbRsp.pready) |=>
            (apbReq.penable && $stable(apbReq.paddr) && $stable(apbReq.pwrite)
             && $stable(apbReq.pwdata)));
    aApbDrop: assert property (@(posedge clk) disable iff (!rstN)
        (apbReq.penable && apbRsp.pready) |=> !apbReq.penable);

endmodule

`default_nettype wire

// File: src/mcpuTop.sv
`default_nettype none

module mcpuTop (
    input  wire               clk,
    input  wire               rstN,
    output ctrlPkg::apbReq_t  apbReq,
    input  ctrlPkg::apbRsp_t  apbRsp,
    output logic              halted,
    output logic              fault,
    output isaPkg::word_t     pc
);
    import isaPkg::*;
    import ctrlPkg::*;

    cpuState_t state;
    ctrl_t     ctrl;
    aluOp_t    aluOp;
    opcode_t   opcode;
    funct3_t   funct3;
    logic      funct7b5;
    logic      zero;

    controlFsm uFsm (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .zero     (zero),
        .apbRsp   (apbRsp),
        .state    (state),
        .aluOp    (aluOp),
        .halted   (halted),
        .fault    (fault)
    );

    controlDecode uDecode (
        .state (state),
        .ctrl  (ctrl)
    );

    datapath uDatapath (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .aluOp    (aluOp),
        .apbRsp   (apbRsp),
        .apbReq   (apbReq),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .zero     (zero),
        .pc       (pc)
    );

endmodule

`default_nettype wire

// File: test/mcpuTb.sv
`default_nettype none

`include "mcpu_cfg.svh"

module mcpuTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int MemWords     = 1 << `MCPU_MEM_AW;
    localparam int DataWords    = 128;
    localparam int TraceBase    = 'h40;
    localparam int MaxWait      = 3;
    localparam int StartTimeout = 20;
    localparam int HaltTimeout  = 2000;

    logic    clk;
    logic    rstN;
    apbReq_t apbReq;
    apbRsp_t apbRsp;
    logic    halted;
    logic    fault;
    word_t   pc;

    word_t       testData [DataWords];
    word_t       mem [MemWords];
    logic [31:0] rngState;
    int          numStores;
    int          storeIdx;
    int          waitLeft;
    logic        rstSeen;
    apbReq_t     prevReq;
    logic        prevReady;

    mcpuTop i_dut (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .halted (halted),
        .fault  (fault),
        .pc     (pc)
    );

    always #5 clk = ~clk;

    // Reset as the DUT saw it at the last rising edge
    always @(posedge clk) begin
        rstSeen <= rstN;
    end

    task automatic abortRun(input string what);
        $display("ERROR: %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic flagMismatch(input string name, input word_t expected, input word_t actual);
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Compares this cycle's request with the one sampled a cycle earlier
    task automatic checkProtocol();
        if (apbReq.penable) begin
            assert (apbReq.psel) else abortRun("penable is high while psel is low");
            assert (prevReq.psel && (!prevReq.penable || !prevReady))
                else abortRun("access phase started without a setup cycle");
        end
        if (prevReq.psel && !prevReq.penable) begin
            assert (apbReq.psel && apbReq.penable)
                else abortRun("setup cycle was not followed by an access phase");
        end
        if (prevReq.penable && !prevReady) begin
            assert (apbReq.penable) else abortRun("access phase ended before pready");
            assert (apbReq.paddr == prevReq.paddr)
                else flagMismatch("paddr hold", prevReq.paddr, apbReq.paddr);
            assert (apbReq.pwrite == prevReq.pwrite)
                else flagMismatch("pwrite hold", word_t'(prevReq.pwrite), word_t'(apbReq.pwrite));
            assert (apbReq.pwdata == prevReq.pwdata)
                else flagMismatch("pwdata hold", prevReq.pwdata, apbReq.pwdata);
        end
    endtask

    task automatic checkStore();
        word_t expAddr;
        word_t expData;
        assert (storeIdx < numStores) else abortRun("store beyond the end of the expected trace");
        expAddr = testData[TraceBase + 1 + 2 * storeIdx];
        expData = testData[TraceBase + 2 + 2 * storeIdx];
        assert (apbReq.paddr == expAddr)
            else flagMismatch($sformatf("store %0d address", storeIdx), expAddr, apbReq.paddr);
        assert (apbReq.pwdata == expData)
            else flagMismatch($sformatf("store %0d data", storeIdx), expData, apbReq.pwdata);
        storeIdx++;
    endtask

    // Memory completer with a random number of wait states per transfer
    task automatic serveMemory();
        int idx;
        apbRsp.pready  = 1'b0;
        apbRsp.pslverr = 1'b0;
        if (apbReq.psel && !apbReq.penable) begin
            rngState = xorshift32(rngState);
            waitLeft = rngState % (MaxWait + 1);
        end else if (apbReq.psel && apbReq.penable) begin
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                assert (((apbReq.paddr >> (`MCPU_MEM_AW + 2)) == 0)
                        && (apbReq.paddr[1:0] == 2'b00))
                    else abortRun("APB address is outside the memory or misaligned");
                idx = apbReq.paddr[`MCPU_MEM_AW+1:2];
                apbRsp.pready = 1'b1;
                if (apbReq.pwrite) begin
                    checkStore();
                    mem[idx] = apbReq.pwdata;
                end else begin
                    apbRsp.prdata = mem[idx];
                end
            end
        end
    endtask

    // pready is recorded after the response for this cycle's request is driven
    always @(negedge clk) begin
        if (rstSeen === 1'b1) begin
            checkProtocol();
        end
        prevReq = apbReq;
        serveMemory();
        prevReady = apbRsp.pready;
    end

    initial begin
        int i;
        int cycles;
        clk       = 1'b0;
        rstN      = 1'b0;
        apbRsp    = '0;
        rngState  = 32'h36b1;
        storeIdx  = 0;
        waitLeft  = 0;
        prevReady = 1'b0;

        $readmemh("test/mcpu_testdata.txt", testData);
        assert (!$isunknown(testData[TraceBase]))
            else abortRun("test data file is missing or has no store count");
        numStores = testData[TraceBase];
        assert (!$isunknown(testData[TraceBase + 1 + 2 * numStores]))
            else abortRun("test data file has no expected halt PC");

        // Unused words get a pattern spread over every address bit
        for (i = 0; i < MemWords; i++) begin
            mem[i] = 32'hdead_0000 ^ (i * 32'h9e37_79b9);
        end
        for (i = 0; i < TraceBase; i++) begin
            if (!$isunknown(testData[i])) begin
                mem[i] = testData[i];
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        assert (apbReq.penable == 1'b0) else abortRun("penable is high right after reset");
        assert (halted == 1'b0) else abortRun("halted is high right after reset");
        assert (fault == 1'b0) else abortRun("fault is high right after reset");

        // First access phase after reset is the first fetch
        for (cycles = 0; cycles < StartTimeout && !apbReq.penable; cycles++) begin
            @(negedge clk);
        end
        assert (apbReq.penable) else abortRun("timeout waiting for the first APB transfer");
        assert (apbReq.paddr == `MCPU_RESET_PC)
            else flagMismatch("first fetch address", `MCPU_RESET_PC, apbReq.paddr);

        for (cycles = 0; cycles < HaltTimeout && !halted; cycles++) begin
            @(negedge clk);
            assert (!fault) else abortRun("core entered the fault state");
        end
        assert (halted) else abortRun("timeout waiting for halted after ecall");

        @(negedge clk);
        assert (pc == testData[TraceBase + 1 + 2 * numStores])
            else flagMismatch("halt PC", testData[TraceBase + 1 + 2 * numStores], pc);
        assert (storeIdx == numStores)
            else flagMismatch("stores seen", word_t'(numStores), word_t'(storeIdx));
        assert (!fault) else abortRun("fault is high after halt");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
src/isaPkg.sv
src/ctrlPkg.sv
src/controlFsm.sv
src/controlDecode.sv
src/regFile.sv
src/aluUnit.sv
src/datapath.sv
src/mcpuTop.sv
test/mcpuTb.sv

// File: test/mcpu_testdata.txt
// Index 0 on: program words, four per line, in fetch order
// Index 0x40 on: store count, then store address and data pairs, then halt PC
@00
06C00093 FEB00113 20000513 002081B3
40208233 0020F2B3 0020E333 0020A3B3
00112433 ABCDE4B7 00352023 00452223
00552423 00652623 00752823 00852A23
00952C23 00252E23 01852583 02B52023
00038463 02152223 00208463 02152423
0080066F 02252623 02C52823 07D00693
00068767 02252A23 02252C23 02E52E23
00000073
@40
0000000C
00000200 00000057  00000204 00000081  00000208 00000068
0000020C FFFFFFEF  00000210 00000000  00000214 00000001
00000218 ABCDE000  0000021C FFFFFFEB  00000220 ABCDE000
00000228 0000006C  00000230 00000064  0000023C 00000074
00000084
